/* bench/i3c_assert.sv */
// Concurrent checks on the CPU-interface handshake, RX queue flags and bus events, with bind
`timescale 1ns/10ps
`default_nettype none

module i3c_assert (
  input wire                      clk_i,
  input wire                      rst_i,
  input wire i3c_pkg::cpuif_req_t req_i,
  input wire i3c_pkg::cpuif_rsp_t rsp_i,
  input wire                      rx_empty_i,
  input wire                      rx_full_i,
  input wire                      bus_start_i,
  input wire                      bus_stop_i
);

  int unsigned fail_count = 0;

  // Ack comes exactly one cycle after req, never on its own
  ack_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
    req_i.req |=> rsp_i.ack)
    else begin
      $error("ack missing one cycle after req");
      fail_count++;
    end

  ack_only_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_i.ack |-> $past(req_i.req))
    else begin
      $error("ack without a request in the previous cycle");
      fail_count++;
    end

  empty_full_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
    !(rx_empty_i && rx_full_i))
    else begin
      $error("RX queue empty and full at once");
      fail_count++;
    end

  start_stop_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
    !(bus_start_i && bus_stop_i))
    else begin
      $error("START and STOP pulses in the same cycle");
      fail_count++;
    end

endmodule

bind i3c i3c_assert i_i3c_assert (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .req_i      (cpuif_req_i),
  .rsp_i      (cpuif_rsp_o),
  .rx_empty_i (rx_empty),
  .rx_full_i  (rx_full),
  .bus_start_i(bus_start),
  .bus_stop_i (bus_stop)
);

`default_nettype wire

/* bench/i3c_tb.sv */
// Testbench with clock, bus frame driver, stimulus tables, compare tasks and watchdog
`timescale 1ns/10ps
`default_nettype none

module i3c_tb;

  localparam int unsigned RxQueueDepth = 4;
  localparam int unsigned NumCtrl      = 5;
  localparam int unsigned ThldBase     = RxQueueDepth;
  localparam int unsigned OvfBase      = RxQueueDepth + 2;
  localparam int unsigned NumFrames    = 2 * RxQueueDepth + 3;
  localparam int unsigned WatchdogClks = (NumCtrl + NumFrames) * 200 + 2000;
  // Last entry leaves the bus released
  localparam logic [NumCtrl-1:0][2:0] CtrlTbl = {3'b011, 3'b100, 3'b110, 3'b101, 3'b000};

  typedef struct packed {
    i3c_pkg::bus_addr_t addr;
    logic [31:0]        exp_data;
  } frame_t;

  logic                clk;
  logic                rst;
  i3c_pkg::cpuif_req_t cpuif_req;
  i3c_pkg::cpuif_rsp_t cpuif_rsp;
  i3c_pkg::bus_pins_t  bus_in;
  i3c_pkg::bus_pins_t  bus_out;
  logic                sel_od_pp;
  frame_t              frame_tbl [NumFrames];

  i3c #(
    .RxQueueDepth(RxQueueDepth)
  ) i_i3c (
    .clk_i      (clk),
    .rst_i      (rst),
    .cpuif_req_i(cpuif_req),
    .cpuif_rsp_o(cpuif_rsp),
    .i3c_bus_i  (bus_in),
    .i3c_bus_o  (bus_out),
    .sel_od_pp_o(sel_od_pp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    repeat (WatchdogClks) @(posedge clk);
    abort_run("Watchdog expired before the tests finished");
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_rsp(input string name, input i3c_pkg::cpuif_rsp_t got,
                           input i3c_pkg::cpuif_rsp_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED cpuif_rsp_o %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_pins(input string name, input i3c_pkg::bus_pins_t got,
                            input i3c_pkg::bus_pins_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // Expected STATUS word from queue occupancy and the sticky flags
  function automatic logic [31:0] status_word(input int count, input int thld,
                                              input logic ovf, input logic start_seen,
                                              input logic stop_seen);
    logic [31:0] w;
    w = '0;
    w[i3c_pkg::STS_RX_EMPTY]   = (count == 0);
    w[i3c_pkg::STS_RX_FULL]    = (count == RxQueueDepth);
    w[i3c_pkg::STS_RX_THLD]    = (thld != 0) && (count >= thld);
    w[i3c_pkg::STS_OVERFLOW]   = ovf;
    w[i3c_pkg::STS_START_SEEN] = start_seen;
    w[i3c_pkg::STS_STOP_SEEN]  = stop_seen;
    return w;
  endfunction

  // One-cycle req pulse, response sampled on the falling edge
  task automatic csr_access(input logic is_wr, input i3c_pkg::csr_addr_e addr,
                            input logic [31:0] wdata, output i3c_pkg::cpuif_rsp_t rsp);
    i3c_pkg::cpuif_req_t req_v;
    logic                got_ack;
    req_v.req   = 1'b1;
    req_v.is_wr = is_wr;
    req_v.addr  = addr;
    req_v.wdata = wdata;
    rsp         = '0;
    got_ack     = 1'b0;
    @(posedge clk);
    cpuif_req <= req_v;
    @(posedge clk);
    cpuif_req.req <= 1'b0;
    for (int i = 0; i < 4 && !got_ack; i++) begin
      @(negedge clk);
      if (cpuif_rsp.ack) begin
        got_ack = 1'b1;
        rsp     = cpuif_rsp;
      end
    end
    if (!got_ack) begin
      abort_run($sformatf("No ack from the CPU interface for address 0x%h", addr));
    end
  endtask

  task automatic read_check(input string name, input i3c_pkg::csr_addr_e addr,
                            input logic exp_err, input logic [31:0] exp_data);
    i3c_pkg::cpuif_rsp_t got;
    i3c_pkg::cpuif_rsp_t exp;
    csr_access(1'b0, addr, 32'h0, got);
    exp.ack   = 1'b1;
    exp.err   = exp_err;
    exp.rdata = exp_data;
    check_rsp(name, got, exp);
  endtask

  task automatic write_check(input string name, input i3c_pkg::csr_addr_e addr,
                             input logic [31:0] data, input logic exp_err);
    i3c_pkg::cpuif_rsp_t got;
    i3c_pkg::cpuif_rsp_t exp;
    csr_access(1'b1, addr, data, got);
    exp.ack   = 1'b1;
    exp.err   = exp_err;
    exp.rdata = 32'h0;
    check_rsp(name, got, exp);
  endtask

  // Hold one bus level for a phase of 8 clocks
  task automatic drive_phase(input logic scl, input logic sda);
    @(posedge clk);
    bus_in.scl <= scl;
    bus_in.sda <= sda;
    repeat (7) @(posedge clk);
  endtask

  task automatic send_frame(input i3c_pkg::bus_addr_t addr);
    drive_phase(1'b1, 1'b0);
    for (int b = 7; b >= 0; b--) begin
      drive_phase(1'b0, addr[b]);
      drive_phase(1'b1, addr[b]);
    end
    // SDA low under SCL low, then rises while SCL is high
    drive_phase(1'b0, 1'b0);
    drive_phase(1'b1, 1'b0);
    drive_phase(1'b1, 1'b1);
  endtask

  initial begin
    i3c_pkg::ctrl_reg_t ctrl_v;
    i3c_pkg::bus_pins_t pins_exp;
    void'($urandom(32'h4fc245ed));
    rst       = 1'b1;
    cpuif_req = '0;
    bus_in    = '1;
    for (int k = 0; k < NumFrames; k++) begin
      frame_tbl[k].addr     = i3c_pkg::bus_addr_t'($urandom);
      frame_tbl[k].exp_data = {24'h0, frame_tbl[k].addr};
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    read_check("CTRL after reset", i3c_pkg::CSR_CTRL, 1'b0, 32'h3);
    read_check("STATUS after reset", i3c_pkg::CSR_STATUS, 1'b0, status_word(0, 1, 0, 0, 0));
    pins_exp.scl = 1'b1;
    pins_exp.sda = 1'b1;
    check_pins("i3c_bus_o after reset", bus_out, pins_exp);
    check_flag("sel_od_pp_o after reset", sel_od_pp, 1'b0);

    for (int i = 0; i < NumCtrl; i++) begin
      ctrl_v = i3c_pkg::ctrl_reg_t'(CtrlTbl[i]);
      write_check("CTRL write", i3c_pkg::CSR_CTRL, 32'(CtrlTbl[i]), 1'b0);
      // Register edge is behind us, the PHY edge comes next
      @(negedge clk);
      pins_exp.scl = ctrl_v.scl;
      pins_exp.sda = ctrl_v.sda;
      check_pins("i3c_bus_o", bus_out, pins_exp);
      check_flag("sel_od_pp_o", sel_od_pp, ctrl_v.sel_od_pp);
      read_check("CTRL readback", i3c_pkg::CSR_CTRL, 1'b0, 32'(CtrlTbl[i]));
    end

    // Address capture
    for (int k = 0; k < RxQueueDepth; k++) begin
      send_frame(frame_tbl[k].addr);
    end
    read_check("STATUS after frames", i3c_pkg::CSR_STATUS, 1'b0,
               status_word(RxQueueDepth, 1, 0, 1, 1));
    for (int k = 0; k < RxQueueDepth; k++) begin
      read_check("RX_DATA", i3c_pkg::CSR_RX_DATA, 1'b0, frame_tbl[k].exp_data);
    end
    read_check("STATUS after reads", i3c_pkg::CSR_STATUS, 1'b0, status_word(0, 1, 0, 1, 1));
    write_check("STATUS clear", i3c_pkg::CSR_STATUS, 32'h30, 1'b0);
    read_check("STATUS after clear", i3c_pkg::CSR_STATUS, 1'b0, status_word(0, 1, 0, 0, 0));

    // Threshold of two
    write_check("RX_THLD write", i3c_pkg::CSR_RX_THLD, 32'h2, 1'b0);
    read_check("RX_THLD readback", i3c_pkg::CSR_RX_THLD, 1'b0, 32'h2);
    send_frame(frame_tbl[ThldBase].addr);
    read_check("STATUS one frame", i3c_pkg::CSR_STATUS, 1'b0, status_word(1, 2, 0, 1, 1));
    send_frame(frame_tbl[ThldBase+1].addr);
    read_check("STATUS two frames", i3c_pkg::CSR_STATUS, 1'b0, status_word(2, 2, 0, 1, 1));
    for (int k = ThldBase; k < OvfBase; k++) begin
      read_check("RX_DATA", i3c_pkg::CSR_RX_DATA, 1'b0, frame_tbl[k].exp_data);
    end
    write_check("STATUS clear", i3c_pkg::CSR_STATUS, 32'h30, 1'b0);

    // One frame more than the queue holds
    for (int k = OvfBase; k < NumFrames; k++) begin
      send_frame(frame_tbl[k].addr);
    end
    read_check("STATUS overflow", i3c_pkg::CSR_STATUS, 1'b0,
               status_word(RxQueueDepth, 2, 1, 1, 1));
    for (int k = OvfBase; k < OvfBase + RxQueueDepth; k++) begin
      read_check("RX_DATA", i3c_pkg::CSR_RX_DATA, 1'b0, frame_tbl[k].exp_data);
    end
    read_check("RX_DATA when empty", i3c_pkg::CSR_RX_DATA, 1'b1, 32'h0);
    write_check("STATUS overflow clear", i3c_pkg::CSR_STATUS, 32'h8, 1'b0);
    read_check("STATUS after overflow clear", i3c_pkg::CSR_STATUS, 1'b0,
               status_word(0, 2, 0, 1, 1));

    read_check("unmapped read", i3c_pkg::csr_addr_e'(4'h2), 1'b1, 32'h0);
    write_check("unmapped write", i3c_pkg::csr_addr_e'(4'h6), 32'hffff_ffff, 1'b1);

    if (i_i3c.i_i3c_assert.fail_count == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      abort_run("Concurrent assertions failed during the run");
    end
  end

endmodule

`default_nettype wire

/* hdl/bus_monitor.sv */
// START/STOP detector and first-byte address capture
`timescale 1ns/10ps
`default_nettype none

module bus_monitor (
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  wire i3c_pkg::bus_pins_t bus_i,
  output logic                    bus_start_o,
  output logic                    bus_stop_o,
  output i3c_pkg::bus_addr_t      addr_o,
  output logic                    addr_valid_o
);

  typedef enum logic [1:0] {
    MON_IDLE,
    MON_ADDR,
    MON_WAIT
  } mon_state_e;

  mon_state_e         state_q;
  i3c_pkg::bus_pins_t prev_q;
  logic [2:0]         bit_cnt_q;
  i3c_pkg::bus_addr_t shift_q;

  logic start_det;
  logic stop_det;
  logic scl_rise;

  // SDA edges while SCL stays high
  assign start_det = prev_q.scl & bus_i.scl & prev_q.sda & ~bus_i.sda;
  assign stop_det  = prev_q.scl & bus_i.scl & ~prev_q.sda & bus_i.sda;
  assign scl_rise  = ~prev_q.scl & bus_i.scl;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prev_q <= '1;
    end else begin
      prev_q <= bus_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q      <= MON_IDLE;
      bit_cnt_q    <= '0;
      bus_start_o  <= 1'b0;
      bus_stop_o   <= 1'b0;
      addr_valid_o <= 1'b0;
    end else begin
      bus_start_o  <= start_det;
      bus_stop_o   <= stop_det;
      addr_valid_o <= 1'b0;
      if (start_det) begin
        // Repeated START restarts the capture as well
        state_q   <= MON_ADDR;
        bit_cnt_q <= '0;
      end else if (stop_det) begin
        state_q <= MON_IDLE;
      end else if (state_q == MON_ADDR && scl_rise) begin
        if (bit_cnt_q == 3'd7) begin
          addr_valid_o <= 1'b1;
          state_q      <= MON_WAIT;
        end else begin
          bit_cnt_q <= bit_cnt_q + 3'd1;
        end
      end
    end
  end

  // MSB first, sampled on SCL rising
  always_ff @(posedge clk_i) begin
    if (state_q == MON_ADDR && scl_rise && !start_det && !stop_det) begin
      shift_q <= {shift_q[6:0], bus_i.sda};
    end
  end

  assign addr_o = shift_q;

endmodule

`default_nettype wire

/* hdl/csr_block.sv */
// CPU-interface register file with control, status, queue pop and threshold
`timescale 1ns/10ps
`default_nettype none

module csr_block #(
  parameter int unsigned RxQueueDepth = 4
) (
  input  wire                        clk_i,
  input  wire                        rst_i,
  input  wire i3c_pkg::cpuif_req_t   req_i,
  output i3c_pkg::cpuif_rsp_t        rsp_o,
  output i3c_pkg::ctrl_reg_t         ctrl_o,
  input  wire                        bus_start_i,
  input  wire                        bus_stop_i,
  output logic                       rx_pop_o,
  output logic [$clog2(RxQueueDepth):0] rx_thld_o,
  input  wire i3c_pkg::bus_addr_t    rx_head_i,
  input  wire                        rx_empty_i,
  input  wire                        rx_full_i,
  input  wire                        rx_thld_trig_i,
  input  wire                        rx_overflow_i,
  output logic                       rx_overflow_clr_o
);

  localparam int unsigned ThldWidth = $clog2(RxQueueDepth) + 1;
  localparam int unsigned DataWidth = i3c_pkg::CsrDataWidth;

  i3c_pkg::ctrl_reg_t   ctrl_q;
  logic [ThldWidth-1:0] thld_q;
  logic                 start_seen_q;
  logic                 stop_seen_q;
  logic                 ack_q;
  logic                 err_q;
  logic [DataWidth-1:0] rdata_q;

  logic                 rd_req;
  logic                 wr_req;
  logic                 sts_wr;
  logic                 addr_hit;
  logic [DataWidth-1:0] status;
  logic [DataWidth-1:0] rd_data;

  assign rd_req = req_i.req & ~req_i.is_wr;
  assign wr_req = req_i.req & req_i.is_wr;
  assign sts_wr = wr_req && (req_i.addr == i3c_pkg::CSR_STATUS);

  always_comb begin
    status                          = '0;
    status[i3c_pkg::STS_RX_EMPTY]   = rx_empty_i;
    status[i3c_pkg::STS_RX_FULL]    = rx_full_i;
    status[i3c_pkg::STS_RX_THLD]    = rx_thld_trig_i;
    status[i3c_pkg::STS_OVERFLOW]   = rx_overflow_i;
    status[i3c_pkg::STS_START_SEEN] = start_seen_q;
    status[i3c_pkg::STS_STOP_SEEN]  = stop_seen_q;
  end

  // Address decode and read mux
  always_comb begin
    addr_hit = 1'b1;
    rd_data  = '0;
    case (req_i.addr)
      i3c_pkg::CSR_CTRL:    rd_data = DataWidth'(ctrl_q);
      i3c_pkg::CSR_STATUS:  rd_data = status;
      i3c_pkg::CSR_RX_DATA: rd_data = rx_empty_i ? '0 : DataWidth'(rx_head_i);
      i3c_pkg::CSR_RX_THLD: rd_data = DataWidth'(thld_q);
      default:              addr_hit = 1'b0;
    endcase
  end

  // Head byte is sampled into the response on the same edge as the pop
  assign rx_pop_o = rd_req && (req_i.addr == i3c_pkg::CSR_RX_DATA) && !rx_empty_i;
  assign rx_overflow_clr_o = sts_wr & req_i.wdata[i3c_pkg::STS_OVERFLOW];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= req_i.req;
      err_q <= req_i.req & (~addr_hit |
               (rd_req & (req_i.addr == i3c_pkg::CSR_RX_DATA) & rx_empty_i));
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= rd_req ? rd_data : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ctrl_q <= i3c_pkg::CTRL_RESET;
      thld_q <= ThldWidth'(1);
    end else if (wr_req) begin
      if (req_i.addr == i3c_pkg::CSR_CTRL) begin
        ctrl_q <= i3c_pkg::ctrl_reg_t'(req_i.wdata[$bits(i3c_pkg::ctrl_reg_t)-1:0]);
      end
      if (req_i.addr == i3c_pkg::CSR_RX_THLD) begin
        thld_q <= req_i.wdata[ThldWidth-1:0];
      end
    end
  end

  // Sticky bus events, a new event wins over a clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      start_seen_q <= 1'b0;
      stop_seen_q  <= 1'b0;
    end else begin
      if (bus_start_i) start_seen_q <= 1'b1;
      else if (sts_wr && req_i.wdata[i3c_pkg::STS_START_SEEN]) start_seen_q <= 1'b0;
      if (bus_stop_i) stop_seen_q <= 1'b1;
      else if (sts_wr && req_i.wdata[i3c_pkg::STS_STOP_SEEN]) stop_seen_q <= 1'b0;
    end
  end

  always_comb begin
    rsp_o.ack   = ack_q;
    rsp_o.err   = err_q;
    rsp_o.rdata = rdata_q;
  end

  assign ctrl_o    = ctrl_q;
  assign rx_thld_o = thld_q;

endmodule

`default_nettype wire

/* hdl/i3c.sv */
// Top level with PHY, bus monitor, RX address queue and CSR block
`timescale 1ns/10ps
`default_nettype none

module i3c #(
  parameter int unsigned RxQueueDepth = 4
) (
  input  wire                        clk_i,
  input  wire                        rst_i,
  input  wire i3c_pkg::cpuif_req_t   cpuif_req_i,
  output i3c_pkg::cpuif_rsp_t        cpuif_rsp_o,
  input  wire i3c_pkg::bus_pins_t    i3c_bus_i,
  output i3c_pkg::bus_pins_t         i3c_bus_o,
  output logic                       sel_od_pp_o
);

  localparam int unsigned RxThldWidth = $clog2(RxQueueDepth) + 1;

  i3c_pkg::bus_pins_t   sync_bus;
  i3c_pkg::ctrl_reg_t   ctrl;

  logic                 bus_start;
  logic                 bus_stop;
  i3c_pkg::bus_addr_t   rx_bus_addr;
  logic                 rx_bus_addr_valid;

  // RX queue <-> CSR
  logic                   rx_pop;
  logic [RxThldWidth-1:0] rx_thld;
  i3c_pkg::bus_addr_t     rx_head;
  logic                   rx_empty;
  logic                   rx_full;
  logic                   rx_thld_trig;
  logic                   rx_overflow;
  logic                   rx_overflow_clr;

  i3c_phy xphy (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .bus_i      (i3c_bus_i),
    .bus_o      (i3c_bus_o),
    .sync_bus_o (sync_bus),
    .ctrl_i     (ctrl),
    .sel_od_pp_o(sel_od_pp_o)
  );

  bus_monitor xbus_monitor (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .bus_i       (sync_bus),
    .bus_start_o (bus_start),
    .bus_stop_o  (bus_stop),
    .addr_o      (rx_bus_addr),
    .addr_valid_o(rx_bus_addr_valid)
  );

  rx_queue #(
    .RxQueueDepth(RxQueueDepth)
  ) xrx_queue (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .push_i        (rx_bus_addr_valid),
    .push_data_i   (rx_bus_addr),
    .pop_i         (rx_pop),
    .head_o        (rx_head),
    .empty_o       (rx_empty),
    .full_o        (rx_full),
    .thld_i        (rx_thld),
    .thld_trig_o   (rx_thld_trig),
    .overflow_o    (rx_overflow),
    .overflow_clr_i(rx_overflow_clr)
  );

  csr_block #(
    .RxQueueDepth(RxQueueDepth)
  ) xcsr (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .req_i            (cpuif_req_i),
    .rsp_o            (cpuif_rsp_o),
    .ctrl_o           (ctrl),
    .bus_start_i      (bus_start),
    .bus_stop_i       (bus_stop),
    .rx_pop_o         (rx_pop),
    .rx_thld_o        (rx_thld),
    .rx_head_i        (rx_head),
    .rx_empty_i       (rx_empty),
    .rx_full_i        (rx_full),
    .rx_thld_trig_i   (rx_thld_trig),
    .rx_overflow_i    (rx_overflow),
    .rx_overflow_clr_o(rx_overflow_clr)
  );

endmodule

`default_nettype wire

/* hdl/i3c_phy.sv */
// Bus pin input synchronizers and output register stage
`timescale 1ns/10ps
`default_nettype none

module i3c_phy (
  input  wire                  clk_i,
  input  wire                  rst_i,
  input  wire i3c_pkg::bus_pins_t bus_i,
  output i3c_pkg::bus_pins_t   bus_o,
  output i3c_pkg::bus_pins_t   sync_bus_o,
  input  wire i3c_pkg::ctrl_reg_t ctrl_i,
  output logic                 sel_od_pp_o
);

  i3c_pkg::bus_pins_t sync_q1;
  i3c_pkg::bus_pins_t sync_q2;

  // Idle bus is high, so the synchronizer starts there too
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync_q1 <= '1;
      sync_q2 <= '1;
    end else begin
      sync_q1 <= bus_i;
      sync_q2 <= sync_q1;
    end
  end

  assign sync_bus_o = sync_q2;

  // Driver select moves on the same edge as SCL and SDA
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bus_o       <= '{scl: i3c_pkg::CTRL_RESET.scl, sda: i3c_pkg::CTRL_RESET.sda};
      sel_od_pp_o <= i3c_pkg::CTRL_RESET.sel_od_pp;
    end else begin
      bus_o       <= '{scl: ctrl_i.scl, sda: ctrl_i.sda};
      sel_od_pp_o <= ctrl_i.sel_od_pp;
    end
  end

endmodule

`default_nettype wire

/* hdl/i3c_pkg.sv */
// Register map, CPU-interface structs, bus pin structs and status bit layout
`default_nettype none

package i3c_pkg;

  localparam int unsigned CsrAddrWidth = 4;
  localparam int unsigned CsrDataWidth = 32;

  // Word-aligned register offsets
  typedef enum logic [CsrAddrWidth-1:0] {
    CSR_CTRL    = 4'h0,
    CSR_STATUS  = 4'h4,
    CSR_RX_DATA = 4'h8,
    CSR_RX_THLD = 4'hC
  } csr_addr_e;

  typedef struct packed {
    logic                    req;
    logic                    is_wr;
    csr_addr_e               addr;
    logic [CsrDataWidth-1:0] wdata;
  } cpuif_req_t;

  typedef struct packed {
    logic                    ack;
    logic                    err;
    logic [CsrDataWidth-1:0] rdata;
  } cpuif_rsp_t;

  typedef struct packed {
    logic scl;
    logic sda;
  } bus_pins_t;

  // Low two bits line up with bus_pins_t, so CTRL reads 0x3 out of reset
  typedef struct packed {
    logic sel_od_pp;
    logic scl;
    logic sda;
  } ctrl_reg_t;

  // 7-bit address followed by RnW
  typedef logic [7:0] bus_addr_t;

  localparam int unsigned STS_RX_EMPTY   = 0;
  localparam int unsigned STS_RX_FULL    = 1;
  localparam int unsigned STS_RX_THLD    = 2;
  localparam int unsigned STS_OVERFLOW   = 3;
  localparam int unsigned STS_START_SEEN = 4;
  localparam int unsigned STS_STOP_SEEN  = 5;

  // Bus released, open-drain driver
  localparam ctrl_reg_t CTRL_RESET = '{sel_od_pp: 1'b0, scl: 1'b1, sda: 1'b1};

endpackage

`default_nettype wire

/* hdl/rx_queue.sv */
// Address byte FIFO with ready threshold and sticky overflow
`timescale 1ns/10ps
`default_nettype none

module rx_queue #(
  parameter int unsigned RxQueueDepth = 4
) (
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  wire                     push_i,
  input  wire i3c_pkg::bus_addr_t push_data_i,
  input  wire                     pop_i,
  output i3c_pkg::bus_addr_t      head_o,
  output logic                    empty_o,
  output logic                    full_o,
  input  wire [$clog2(RxQueueDepth):0] thld_i,
  output logic                    thld_trig_o,
  output logic                    overflow_o,
  input  wire                     overflow_clr_i
);

  localparam int unsigned AddrWidth = $clog2(RxQueueDepth);
  localparam int unsigned PtrWidth  = AddrWidth + 1;

  i3c_pkg::bus_addr_t  mem_q [RxQueueDepth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [PtrWidth-1:0] count;
  logic                wr_en;
  logic                rd_en;

  // Extra pointer bit tells full from empty
  assign count   = wr_ptr_q - rd_ptr_q;
  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign full_o  = (count == PtrWidth'(RxQueueDepth));

  assign rd_en = pop_i & ~empty_o;
  assign wr_en = push_i & ~full_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (wr_en) wr_ptr_q <= wr_ptr_q + PtrWidth'(1);
      if (rd_en) rd_ptr_q <= rd_ptr_q + PtrWidth'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q[AddrWidth-1:0]] <= push_data_i;
    end
  end

  assign head_o = mem_q[rd_ptr_q[AddrWidth-1:0]];

  // A zero threshold never triggers
  assign thld_trig_o = (thld_i != '0) && (count >= thld_i);

  // Clear only takes once the queue has drained below full
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      overflow_o <= 1'b0;
    end else if (push_i && !wr_en) begin
      overflow_o <= 1'b1;
    end else if (overflow_clr_i && !full_o) begin
      overflow_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* vlog.f */
hdl/i3c_pkg.sv
hdl/i3c_phy.sv
hdl/bus_monitor.sv
hdl/rx_queue.sv
hdl/csr_block.sv
hdl/i3c.sv
bench/i3c_assert.sv
bench/i3c_tb.sv
